// File: verilog.f
+incdir+.
sound_pkg.sv
sound_regfile.sv
tone_voice.sv
pwm_level_table.sv
pwm_channel.sv
sound_top.sv
sound_sva.sv
sound_tb.sv

// File: sound_tb.sv
/* Sound generator testbench.
   Register writes through silence, fixed levels, tones and mixing. */

module sound_tb
  import sound_pkg::*;
();

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 3;
  localparam int WRITE_MAX      = 6;                    // Idle, stall and transfer.
  localparam int SILENCE_CYCLES = 200;
  localparam int LEVEL_CYCLES   = 300;
  localparam int TONE_TESTS     = 4;
  localparam int TONE_CYCLES    = 200;
  localparam int MIX_CYCLES     = 50;
  localparam int TEST_CYCLES    = RESET_CYCLES + 2 + 5 * WRITE_MAX + SILENCE_CYCLES
    + 14 * (2 * WRITE_MAX + LEVEL_CYCLES) + 3 * WRITE_MAX + MIX_CYCLES
    + TONE_TESTS * (6 * WRITE_MAX + TONE_CYCLES) + 3 * WRITE_MAX + 2 * MIX_CYCLES;

  logic        clk;
  logic        reset_n;
  logic        reg_valid;
  reg_addr_e   reg_addr;
  logic [7:0]  reg_data;
  logic        reg_ready;
  logic        audio_pwm;
  logic [31:0] lfsr = 32'hc58a;

  sound_top sound_top_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .reg_valid (reg_valid),
    .reg_addr  (reg_addr),
    .reg_data  (reg_data),
    .reg_ready (reg_ready),
    .audio_pwm (audio_pwm)
  );

  bind sound_top sound_sva sva_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .reg_valid (reg_valid),
    .reg_addr  (reg_addr),
    .reg_data  (reg_data),
    .reg_ready (reg_ready),
    .audio_pwm (audio_pwm)
  );

  // ====================
  // Helpers
  // ====================

  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = (lfsr >> 1) ^ (lfsr[0] ? 32'hd000_0001 : 32'h0);   // Galois step.
    end
    return value;
  endfunction

  function automatic reg_addr_e amp_addr(input int voice);
    return reg_addr_e'(8 + voice);
  endfunction

  task automatic wait_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [7:0] data, input int idle);
    wait_cycles(idle);
    reg_valid = 1'b1;
    reg_addr  = addr;
    reg_data  = data;
    while (!reg_ready) wait_cycles(1);                  // Slot still committing.
    wait_cycles(1);
    reg_valid = 1'b0;
  endtask

  // ====================
  // Processes
  // ====================

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(CLK_PERIOD * (TEST_CYCLES + 200));
    $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES + 200);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin : error_monitor
    wait (sound_top_inst.sva_inst.fail_count != 0);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first assertion failure");
  end

  initial begin : stimulus
    int voice;
    int last_voice;
    int period;
    reg_valid  = 1'b0;
    reg_addr   = ADDR_PERIOD_A_LO;
    reg_data   = '0;
    reset_n    = 1'b0;
    last_voice = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    reset_n = 1'b1;
    wait_cycles(2);
    // Back to back writes give deliberate stalls.
    write_reg(ADDR_TONE_EN, 8'h00, 0);
    write_reg(ADDR_AMP_A, 8'h00, 0);
    write_reg(ADDR_AMP_B, 8'h00, 0);
    write_reg(ADDR_AMP_C, 8'h00, 0);
    write_reg(reg_addr_e'(6), 8'hff, take_bits(2));     // Unmapped address.
    wait_cycles(SILENCE_CYCLES);
    for (int n = 1; n <= 14; n++) begin
      voice = n % 3;
      write_reg(amp_addr(voice), 8'(n), take_bits(2));
      write_reg(amp_addr(last_voice), 8'h00, take_bits(2));
      last_voice = voice;
      wait_cycles(LEVEL_CYCLES);
    end
    write_reg(ADDR_AMP_A, 8'hff, take_bits(2));         // Level 15 with upper nibble ignored.
    write_reg(amp_addr(last_voice), 8'h00, take_bits(2));
    wait_cycles(MIX_CYCLES);
    write_reg(ADDR_AMP_A, 8'h00, take_bits(2));
    for (int t = 0; t < TONE_TESTS; t++) begin
      voice  = t % 3;
      period = 2 + take_bits(5) % 19;
      write_reg(reg_addr_e'(2 * voice), 8'(period), take_bits(2));
      write_reg(reg_addr_e'(2 * voice + 1), 8'h00, take_bits(2));
      write_reg(amp_addr(voice), 8'h0f, take_bits(2));
      write_reg(ADDR_TONE_EN, 8'(1 << voice), take_bits(2));
      wait_cycles(TONE_CYCLES);
      write_reg(ADDR_TONE_EN, 8'h00, take_bits(2));
      write_reg(amp_addr(voice), 8'h00, take_bits(2));
    end
    // Mixing two full voices.
    write_reg(ADDR_AMP_A, 8'h0f, take_bits(2));
    write_reg(ADDR_AMP_C, 8'h0f, take_bits(2));
    wait_cycles(MIX_CYCLES);
    write_reg(ADDR_AMP_A, 8'h00, take_bits(2));
    wait_cycles(MIX_CYCLES);
    if (sound_top_inst.sva_inst.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Assertion failures were reported");
    end
  end

endmodule

// File: sound_sva.sv
/* Sound generator checker.
   Bound assertions on the write handshake, silence, fixed levels and tone runs. */

module sound_sva
  import sound_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input logic       reg_valid,
  input logic [3:0] reg_addr,
  input logic [7:0] reg_data,
  input logic       reg_ready,
  input logic       audio_pwm
);

  int          fail_count = 0;                          // Assertion failures so far.
  level_t      amp [3];                                 // Register model.
  period_t     per [3];
  logic [2:0]  en;
  logic        transfer;
  logic [2:0]  nz;
  logic        single;
  logic        sel_en;
  logic        all_zero;
  logic        full_now;
  level_t      sel_amp;
  period_t     sel_per;
  logic        fixed_mode;
  logic        tone_mode;
  logic [15:0] runs;
  int          exp_low;
  int          exp_high;
  logic        prev_pwm;
  logic        rise_seen;
  int          run_len;
  int          quiet;
  int          full_age;

  // Log table as {low run, high run}.
  function automatic logic [15:0] log_runs(input level_t lv);
    case (lv)
      4'd1:    return {8'd64, 8'd1};
      4'd2:    return {8'd48, 8'd1};
      4'd3:    return {8'd32, 8'd1};
      4'd4:    return {8'd24, 8'd1};
      4'd5:    return {8'd16, 8'd1};
      4'd6:    return {8'd12, 8'd1};
      4'd7:    return {8'd8, 8'd1};
      4'd8:    return {8'd6, 8'd1};
      4'd9:    return {8'd4, 8'd1};
      4'd10:   return {8'd3, 8'd1};
      4'd11:   return {8'd2, 8'd1};
      4'd12:   return {8'd3, 8'd2};
      4'd13:   return {8'd1, 8'd1};
      4'd14:   return {8'd1, 8'd2};
      default: return 16'd0;
    endcase
  endfunction

  // ====================
  // Expected behavior
  // ====================

  assign transfer   = reg_valid && reg_ready;
  assign nz         = {amp[2] != 4'd0, amp[1] != 4'd0, amp[0] != 4'd0};
  assign single     = $onehot(nz);
  assign sel_amp    = amp[0] | amp[1] | amp[2];         // Only one voice is nonzero.
  assign sel_en     = |(en & nz);
  assign sel_per    = nz[0] ? per[0] : (nz[1] ? per[1] : per[2]);
  assign all_zero   = (nz == 3'b000);
  assign full_now   = |(~en & {amp[2] == 4'd15, amp[1] == 4'd15, amp[0] == 4'd15});
  assign fixed_mode = single && !sel_en && (sel_amp != 4'd15);
  assign tone_mode  = single && sel_en && (sel_amp == 4'd15);
  assign runs       = log_runs(sel_amp);
  assign exp_low    = tone_mode ? ((sel_per == '0) ? 1 : int'(sel_per)) : int'(runs[15:8]);
  assign exp_high   = tone_mode ? exp_low : int'(runs[7:0]);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      amp       <= '{default: '0};
      per       <= '{default: '0};
      en        <= '0;
      prev_pwm  <= 1'b0;
      rise_seen <= 1'b0;
      run_len   <= 0;
      quiet     <= 0;
      full_age  <= 0;
    end else begin
      prev_pwm <= audio_pwm;
      run_len  <= (audio_pwm != prev_pwm) ? 1 : run_len + 1;
      quiet    <= transfer ? 0 : quiet + 1;             // Cycles since last write.
      full_age <= full_now ? full_age + 1 : 0;
      if (transfer) begin
        rise_seen <= 1'b0;
        case (reg_addr)
          ADDR_PERIOD_A_LO: per[0][7:0] <= reg_data;
          ADDR_PERIOD_A_HI: per[0][11:8] <= reg_data[3:0];
          ADDR_PERIOD_B_LO: per[1][7:0] <= reg_data;
          ADDR_PERIOD_B_HI: per[1][11:8] <= reg_data[3:0];
          ADDR_PERIOD_C_LO: per[2][7:0] <= reg_data;
          ADDR_PERIOD_C_HI: per[2][11:8] <= reg_data[3:0];
          ADDR_TONE_EN:     en <= reg_data[2:0];
          ADDR_AMP_A:       amp[0] <= reg_data[3:0];
          ADDR_AMP_B:       amp[1] <= reg_data[3:0];
          ADDR_AMP_C:       amp[2] <= reg_data[3:0];
          default: ;
        endcase
      end else if (quiet >= 4 && audio_pwm && !prev_pwm) begin
        rise_seen <= 1'b1;                              // First edge after settling.
      end
    end
  end

  // ====================
  // Assertions
  // ====================

  a_reset_idle: assert property (@(posedge clk)
    (!reset_n && $past(!reset_n)) || $rose(reset_n) |-> reg_ready && !audio_pwm)
    else begin
      fail_count++;
      $error("ERROR at %0t: output not idle around reset", $time);
    end

  a_ready_gap: assert property (@(posedge clk) disable iff (!reset_n)
    transfer |=> !reg_ready ##1 reg_ready)
    else begin
      fail_count++;
      $error("ERROR at %0t: reg_ready gap is not one cycle", $time);
    end

  a_hold: assert property (@(posedge clk) disable iff (!reset_n)
    reg_valid && !reg_ready |=> reg_valid && $stable(reg_addr) && $stable(reg_data))
    else begin
      fail_count++;
      $error("ERROR at %0t: write changed during a stall", $time);
    end

  a_silence: assert property (@(posedge clk) disable iff (!reset_n)
    all_zero && quiet >= 4 |-> !audio_pwm)
    else begin
      fail_count++;
      $error("ERROR at %0t: audio_pwm high while silent", $time);
    end

  a_full: assert property (@(posedge clk) disable iff (!reset_n)
    full_age >= 4 |-> audio_pwm)
    else begin
      fail_count++;
      $error("ERROR at %0t: audio_pwm low at full level", $time);
    end

  a_runs: assert property (@(posedge clk) disable iff (!reset_n)
    (fixed_mode || tone_mode) && rise_seen && (audio_pwm != prev_pwm)
      |-> run_len == (prev_pwm ? exp_high : exp_low))
    else begin
      fail_count++;
      $error("ERROR at %0t: PWM run of %0d cycles", $time, run_len);
    end

endmodule

// File: sound_top.sv
/* Sound generator output stage.
   Register file, three tone voices and three log PWM channels ORed onto one pin. */

`include "sound_settings.svh"

module sound_top
  import sound_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       reg_valid,
  input  reg_addr_e  reg_addr,
  input  logic [7:0] reg_data,
  output logic       reg_ready,
  output logic       audio_pwm
);

  period_t                  period_a, period_b, period_c;
  level_t                   amp_a, amp_b, amp_c;
  logic [`SOUND_VOICES-1:0] tone_en;
  level_t                   level_a, level_b, level_c;
  logic                     pwm_a, pwm_b, pwm_c;

  // ====================
  // Registers
  // ====================

  sound_regfile regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .reg_valid (reg_valid),
    .reg_addr  (reg_addr),
    .reg_data  (reg_data),
    .reg_ready (reg_ready),
    .period_a  (period_a),
    .period_b  (period_b),
    .period_c  (period_c),
    .amp_a     (amp_a),
    .amp_b     (amp_b),
    .amp_c     (amp_c),
    .tone_en   (tone_en)
  );

  // ====================
  // Voices and PWM
  // ====================

  tone_voice voice_a (.clk(clk), .reset_n(reset_n), .period(period_a), .amplitude(amp_a),
                      .tone_en(tone_en[0]), .level(level_a));
  tone_voice voice_b (.clk(clk), .reset_n(reset_n), .period(period_b), .amplitude(amp_b),
                      .tone_en(tone_en[1]), .level(level_b));
  tone_voice voice_c (.clk(clk), .reset_n(reset_n), .period(period_c), .amplitude(amp_c),
                      .tone_en(tone_en[2]), .level(level_c));

  pwm_channel pwm_ch_a (.clk(clk), .reset_n(reset_n), .din(level_a), .pwm(pwm_a));
  pwm_channel pwm_ch_b (.clk(clk), .reset_n(reset_n), .din(level_b), .pwm(pwm_b));
  pwm_channel pwm_ch_c (.clk(clk), .reset_n(reset_n), .din(level_c), .pwm(pwm_c));

  // The RC filter outside the pin sums the three bits.
  assign audio_pwm = pwm_a | pwm_b | pwm_c;

endmodule

// File: pwm_channel.sv
/* Logarithmic PWM channel.
   Runs the decoded low and high runs of one level on a single output bit. */

module pwm_channel
  import sound_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  level_t din,
  output logic   pwm
);

  run_t rep0;
  run_t rep1;
  logic zero;
  logic full;

  run_t last0;                                          // Latched low run.
  run_t last1;                                          // Latched high run.
  run_t count;                                          // Cycles into current run.
  run_t end0;
  run_t end1;
  logic changed;

  pwm_level_table dec (
    .din  (din),
    .rep0 (rep0),
    .rep1 (rep1),
    .zero (zero),
    .full (full)
  );

  assign end0    = last0 - run_t'(1);
  assign end1    = last1 - run_t'(1);
  assign changed = (rep0 != last0) || (rep1 != last1);

  // ====================
  // Run sequencer
  // ====================

  // Zero and full are handled first so that a tone toggling between
  // 0 and 15 gives equal high and low times on the pin.
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      last0 <= '0;
      last1 <= '0;
      count <= '0;
      pwm   <= 1'b0;
    end else if (zero || full) begin
      last0 <= rep0;
      last1 <= rep1;
      count <= '0;
      pwm   <= full;                                    // Steady level.
    end else if (changed) begin
      last0 <= rep0;                                    // New level starts a fresh low run.
      last1 <= rep1;
      count <= '0;
      pwm   <= 1'b0;
    end else if (pwm) begin
      if (count == end1) begin
        count <= '0;
        pwm   <= 1'b0;                                  // End of high run.
      end else begin
        count <= count + run_t'(1);
      end
    end else begin
      if (count == end0) begin
        count <= '0;
        pwm   <= 1'b1;                                  // End of low run.
      end else begin
        count <= count + run_t'(1);
      end
    end
  end

endmodule

// File: pwm_level_table.sv
/* Logarithmic PWM decode.
   Maps a 4-bit level to low and high run lengths with zero and full flags. */

module pwm_level_table
  import sound_pkg::*;
(
  input  level_t din,
  output run_t   rep0,
  output run_t   rep1,
  output logic   zero,
  output logic   full
);

  assign zero = (din == level_t'(0));
  assign full = (din == level_t'(15));

  // Roughly 2 dB per step. Level 0 and 15 bypass the runs.
  always_comb begin
    case (din)
      4'd1: begin
        rep0 = run_t'(64);
        rep1 = run_t'(1);
      end
      4'd2: begin
        rep0 = run_t'(48);
        rep1 = run_t'(1);
      end
      4'd3: begin
        rep0 = run_t'(32);
        rep1 = run_t'(1);
      end
      4'd4: begin
        rep0 = run_t'(24);
        rep1 = run_t'(1);
      end
      4'd5: begin
        rep0 = run_t'(16);
        rep1 = run_t'(1);
      end
      4'd6: begin
        rep0 = run_t'(12);
        rep1 = run_t'(1);
      end
      4'd7: begin
        rep0 = run_t'(8);
        rep1 = run_t'(1);
      end
      4'd8: begin
        rep0 = run_t'(6);
        rep1 = run_t'(1);
      end
      4'd9: begin
        rep0 = run_t'(4);
        rep1 = run_t'(1);
      end
      4'd10: begin
        rep0 = run_t'(3);
        rep1 = run_t'(1);
      end
      4'd11: begin
        rep0 = run_t'(2);
        rep1 = run_t'(1);
      end
      4'd12: begin
        rep0 = run_t'(3);
        rep1 = run_t'(2);
      end
      4'd13: begin
        rep0 = run_t'(1);
        rep1 = run_t'(1);
      end
      4'd14: begin
        rep0 = run_t'(1);
        rep1 = run_t'(2);
      end
      default: begin
        rep0 = '0;                                      // Runs unused at zero or full.
        rep1 = '0;
      end
    endcase
  end

endmodule

// File: tone_voice.sv
/* Tone voice.
   Square wave from a half-period counter, gating the amplitude into a level. */

module tone_voice
  import sound_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  period_t period,
  input  level_t  amplitude,
  input  logic    tone_en,
  output level_t  level
);

  period_t count;                                       // Cycles left in this half.
  period_t reload;
  logic    square;
  logic    expire;

  assign reload = (period == '0) ? period_t'(1) : period;   // Zero period acts as one.
  assign expire = (count <= period_t'(1));

  // ====================
  // Half-period counter
  // ====================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count  <= '0;
      square <= 1'b0;
    end else if (expire) begin
      count  <= reload;
      square <= !square;                                // Flip every reload cycles.
    end else begin
      count  <= count - period_t'(1);
    end
  end

  // ====================
  // Amplitude gating
  // ====================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      level <= '0;
    end else if (!tone_en) begin
      level <= amplitude;                               // Fixed level.
    end else begin
      level <= square ? amplitude : level_t'(0);
    end
  end

endmodule

// File: sound_regfile.sv
/* Register file of the sound generator.
   Valid/ready write port with a staging slot that commits into the voice registers. */

`include "sound_settings.svh"

module sound_regfile
  import sound_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     reg_valid,
  input  reg_addr_e                reg_addr,
  input  logic [7:0]               reg_data,
  output logic                     reg_ready,
  output period_t                  period_a,
  output period_t                  period_b,
  output period_t                  period_c,
  output level_t                   amp_a,
  output level_t                   amp_b,
  output level_t                   amp_c,
  output logic [`SOUND_VOICES-1:0] tone_en
);

  // ====================
  // Staging slot
  // ====================

  logic       stage_full;                               // Write waiting to commit.
  reg_addr_e  stage_addr;
  logic [7:0] stage_data;
  logic       transfer;

  assign reg_ready = !stage_full;                       // One write in flight at a time.
  assign transfer  = reg_valid && reg_ready;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage_full <= 1'b0;
    end else begin
      stage_full <= transfer;                           // Slot drains the cycle after fill.
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      stage_addr <= reg_addr;
      stage_data <= reg_data;
    end
  end

  // ====================
  // Voice registers
  // ====================

  // The high address of a period only carries the top nibble.
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      period_a <= '0;
      period_b <= '0;
      period_c <= '0;
      amp_a    <= '0;
      amp_b    <= '0;
      amp_c    <= '0;
      tone_en  <= '0;
    end else if (stage_full) begin
      case (stage_addr)
        ADDR_PERIOD_A_LO: period_a[7:0] <= stage_data;
        ADDR_PERIOD_A_HI: period_a[`SOUND_TONE_WIDTH-1:8] <= stage_data[`SOUND_TONE_WIDTH-9:0];
        ADDR_PERIOD_B_LO: period_b[7:0] <= stage_data;
        ADDR_PERIOD_B_HI: period_b[`SOUND_TONE_WIDTH-1:8] <= stage_data[`SOUND_TONE_WIDTH-9:0];
        ADDR_PERIOD_C_LO: period_c[7:0] <= stage_data;
        ADDR_PERIOD_C_HI: period_c[`SOUND_TONE_WIDTH-1:8] <= stage_data[`SOUND_TONE_WIDTH-9:0];
        ADDR_TONE_EN:     tone_en <= stage_data[`SOUND_VOICES-1:0];
        ADDR_AMP_A:       amp_a <= stage_data[3:0];
        ADDR_AMP_B:       amp_b <= stage_data[3:0];
        ADDR_AMP_C:       amp_c <= stage_data[3:0];
        default: ;                                      // Unmapped address is dropped.
      endcase
    end
  end

endmodule

// File: sound_pkg.sv
/* Sound generator types.
   Level, run length and period types plus the register map. */

`include "sound_settings.svh"

package sound_pkg;

  // ====================
  // Data types
  // ====================

  typedef logic [3:0] level_t;                          // Amplitude or output level.
  typedef logic [`SOUND_RUN_WIDTH-1:0] run_t;           // PWM run in clk cycles.
  typedef logic [`SOUND_TONE_WIDTH-1:0] period_t;       // Tone half-period.

  // ====================
  // Register map
  // ====================

  // Writes to address 6 and 11 to 15 are accepted and dropped.
  typedef enum logic [3:0] {
    ADDR_PERIOD_A_LO = 4'd0,                            // Voice A period bits 7:0.
    ADDR_PERIOD_A_HI = 4'd1,                            // Voice A period bits 11:8.
    ADDR_PERIOD_B_LO = 4'd2,
    ADDR_PERIOD_B_HI = 4'd3,
    ADDR_PERIOD_C_LO = 4'd4,
    ADDR_PERIOD_C_HI = 4'd5,
    ADDR_TONE_EN     = 4'd7,                            // Tone enables, bit 0 is voice A.
    ADDR_AMP_A       = 4'd8,                            // Amplitude in low nibble.
    ADDR_AMP_B       = 4'd9,
    ADDR_AMP_C       = 4'd10
  } reg_addr_e;

endpackage

// File: sound_settings.svh
/* Sound generator sizes.
   Widths of tone periods and PWM runs, and the voice count. */

`ifndef SOUND_SETTINGS_SVH
`define SOUND_SETTINGS_SVH

// Tone half-period in clk cycles.
`define SOUND_TONE_WIDTH 12

// Voices A, B and C.
`define SOUND_VOICES 3

// Longest PWM run is 64 cycles.
`define SOUND_RUN_WIDTH 8

`endif
